//--- design/spi_pkg.sv
`default_nettype none

package spi_pkg;

  //////////////////////////////////////////////////
  // frame geometry

  parameter int spi_data_width = 8; // one byte per frame, msb first

  //////////////////////////////////////////////////
  // timing limits

  // slave sees each line edge this many clk cycles late, plus the edge register
  parameter int spi_sync_stages = 2;

  // smallest sclk half period in clk cycles, keeps the slave's miso
  // settled before the master samples on the falling edge
  parameter int spi_min_halfperiod = 4;

  // master sequencer states
  typedef enum logic [1:0] {
    st_idle,        // cs_n high, sclk low
    st_drive_edge,  // sclk low half, rises at the end
    st_sample_edge, // sclk high half, falls at the end
    st_finalize     // trailing half period before cs_n rises
  } spi_state_t;

endpackage

`default_nettype wire

//--- design/host_pkg.sv
`default_nettype none

package host_pkg;

  //////////////////////////////////////////////////
  // host command set

  typedef enum logic [1:0] {
    op_write     = 2'd0, // send byte, reply dropped
    op_xfer      = 2'd1, // send byte, reply returned
    op_read_last = 2'd2  // no spi traffic, last reply returned
  } host_op_t;

  //////////////////////////////////////////////////
  // command sequencing status

  typedef enum logic [1:0] {
    hs_idle,   // waiting for req
    hs_decode, // op latched, pick a path
    hs_spi,    // frame in flight, waiting for done
    hs_ack     // ack high until req drops
  } host_status_t;

endpackage

`default_nettype wire

//--- design/spi_shift_reg.sv
`timescale 1ns/1ps
`default_nettype none

// one byte shifter shared by both ends of the link
// drive and sample come from the owner, so the same block
// serves the master (sclk generator) and the slave (synced edges)
module spi_shift_reg #(
  parameter int DATA_WIDTH = spi_pkg::spi_data_width
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  load,        // parallel load of a new byte
  input  logic [DATA_WIDTH-1:0] load_data,
  input  logic                  drive,       // present next bit
  input  logic                  sample,      // capture serial_in
  input  logic                  serial_in,
  output logic                  serial_out,
  output logic [DATA_WIDTH-1:0] parallel_out
);

  logic [DATA_WIDTH-1:0] shreg;
  logic                  out_bit;

  //////////////////////////////////////////////////
  // data path

  // msb leaves first, received bits enter at the bottom
  always_ff @(posedge clk) begin
    if (load) begin
      shreg <= load_data;
    end else if (sample) begin
      shreg <= {shreg[DATA_WIDTH-2:0], serial_in};
    end
  end

  // output bit is held between drive strobes
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      out_bit <= 1'b0;
    end else if (drive) begin
      out_bit <= shreg[DATA_WIDTH-1]; // taken before the matching sample shifts
    end
  end

  assign serial_out   = out_bit;
  assign parallel_out = shreg; // received byte once all bits are in

  //////////////////////////////////////////////////
  // checks

  // a load landing on a sample would drop a received bit
  a_load_sample_excl : assert property (
    @(posedge clk) disable iff (rst) !(load && sample)
  ) else $error("spi_shift_reg: load and sample in the same cycle");

endmodule

`default_nettype wire

//--- design/spi_master.sv
`timescale 1ns/1ps
`default_nettype none

// mode 1 master: sclk idles low, data driven on the rising edge,
// sampled on the falling edge
module spi_master #(
  parameter int DATA_WIDTH      = spi_pkg::spi_data_width,
  parameter int SCLK_HALFPERIOD = spi_pkg::spi_min_halfperiod
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  start,
  input  logic [DATA_WIDTH-1:0] tx_data,
  input  logic                  miso,
  output logic                  busy,
  output logic                  done,
  output logic [DATA_WIDTH-1:0] rx_data,
  output logic                  sclk,
  output logic                  cs_n,
  output logic                  mosi
);

  import spi_pkg::*;

  localparam int HP_W  = $clog2(SCLK_HALFPERIOD + 1);
  localparam int BIT_W = $clog2(DATA_WIDTH + 1);

  localparam logic [HP_W-1:0]  HP_LAST  = HP_W'(SCLK_HALFPERIOD - 1);
  localparam logic [BIT_W-1:0] BIT_LAST = BIT_W'(DATA_WIDTH - 1);

  spi_state_t       state;
  logic [HP_W-1:0]  hp_cnt;  // cycles left in this half period
  logic [BIT_W-1:0] bit_cnt; // bits left after the current one
  logic             hp_end;
  logic             load;
  logic             drive;
  logic             sample;

  assign hp_end = (hp_cnt == '0);
  assign busy   = (state != st_idle);
  assign load   = start && (state == st_idle); // start while busy is dropped
  assign drive  = (state == st_drive_edge) && hp_end;  // same edge as sclk rise
  assign sample = (state == st_sample_edge) && hp_end; // same edge as sclk fall

  //////////////////////////////////////////////////
  // sequencer

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state   <= st_idle;
      hp_cnt  <= HP_LAST;
      bit_cnt <= '0;
      sclk    <= 1'b0;
      cs_n    <= 1'b1;
      done    <= 1'b0;
    end else begin
      done <= 1'b0;

      // every active state reloads at the end of its half period
      if (busy) begin
        hp_cnt <= hp_end ? HP_LAST : hp_cnt - 1'b1;
      end

      case (state)
        st_idle: begin
          if (start) begin
            cs_n    <= 1'b0;
            hp_cnt  <= HP_LAST;
            bit_cnt <= BIT_LAST;
            state   <= st_drive_edge;
          end
        end
        st_drive_edge: begin
          if (hp_end) begin
            sclk  <= 1'b1;
            state <= st_sample_edge;
          end
        end
        st_sample_edge: begin
          if (hp_end) begin
            sclk <= 1'b0;
            if (bit_cnt == '0) begin
              state <= st_finalize;
            end else begin
              bit_cnt <= bit_cnt - 1'b1;
              state   <= st_drive_edge;
            end
          end
        end
        st_finalize: begin
          if (hp_end) begin
            cs_n  <= 1'b1; // deselect and done in the same cycle
            done  <= 1'b1;
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // shifter

  spi_shift_reg #(
    .DATA_WIDTH (DATA_WIDTH)
  ) spi_shift_reg_inst (
    .clk          (clk),
    .rst          (rst),
    .load         (load),
    .load_data    (tx_data),
    .drive        (drive),
    .sample       (sample),
    .serial_in    (miso),
    .serial_out   (mosi),
    .parallel_out (rx_data)
  );

  //////////////////////////////////////////////////
  // checks

  // slave needs sync plus edge detect before miso settles
  a_halfperiod_min : assert property (
    @(posedge clk) SCLK_HALFPERIOD >= spi_min_halfperiod
  ) else $error("spi_master: SCLK_HALFPERIOD below %0d", spi_min_halfperiod);

  a_sclk_in_frame : assert property (
    @(posedge clk) disable iff (rst) sclk |-> !cs_n
  ) else $error("spi_master: sclk high outside a frame");

  a_done_pulse : assert property (
    @(posedge clk) disable iff (rst) done |=> !done
  ) else $error("spi_master: done wider than one cycle");

endmodule

`default_nettype wire

//--- design/spi_slave_device.sv
`timescale 1ns/1ps
`default_nettype none

// on-chip slave model
// every frame answers with the byte received in the frame before
module spi_slave_device #(
  parameter int DATA_WIDTH = spi_pkg::spi_data_width
) (
  input  logic clk,
  input  logic rst,
  input  logic sclk,
  input  logic cs_n,
  input  logic mosi,
  output logic miso
);

  import spi_pkg::*;

  logic [spi_sync_stages-1:0] sclk_sync;
  logic [spi_sync_stages-1:0] cs_n_sync;
  logic [spi_sync_stages-1:0] mosi_sync;
  logic                       sclk_s;
  logic                       cs_n_s;
  logic                       mosi_s;
  logic                       sclk_d;     // edge register
  logic                       cs_n_d;
  logic                       sclk_rise;
  logic                       sclk_fall;
  logic                       cs_fall;
  logic                       cs_rise;
  logic [DATA_WIDTH-1:0]      reply;      // byte sent in the next frame
  logic [DATA_WIDTH-1:0]      rx_byte;
  logic                       tx_bit;

  //////////////////////////////////////////////////
  // line synchronizers and edge detect

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      sclk_sync <= '0;
      cs_n_sync <= '1; // deselected
      mosi_sync <= '0;
      sclk_d    <= 1'b0;
      cs_n_d    <= 1'b1;
    end else begin
      sclk_sync <= {sclk_sync[spi_sync_stages-2:0], sclk};
      cs_n_sync <= {cs_n_sync[spi_sync_stages-2:0], cs_n};
      mosi_sync <= {mosi_sync[spi_sync_stages-2:0], mosi};
      sclk_d    <= sclk_s;
      cs_n_d    <= cs_n_s;
    end
  end

  assign sclk_s = sclk_sync[spi_sync_stages-1];
  assign cs_n_s = cs_n_sync[spi_sync_stages-1];
  assign mosi_s = mosi_sync[spi_sync_stages-1];

  assign sclk_rise = sclk_s && !sclk_d;
  assign sclk_fall = !sclk_s && sclk_d;
  assign cs_fall   = !cs_n_s && cs_n_d; // frame start
  assign cs_rise   = cs_n_s && !cs_n_d; // frame end

  //////////////////////////////////////////////////
  // reply register

  // last frame's byte becomes the next answer
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      reply <= '0;
    end else if (cs_rise) begin
      reply <= rx_byte;
    end
  end

  spi_shift_reg #(
    .DATA_WIDTH (DATA_WIDTH)
  ) spi_shift_reg_inst (
    .clk          (clk),
    .rst          (rst),
    .load         (cs_fall),
    .load_data    (reply),
    .drive        (sclk_rise && !cs_n_s),
    .sample       (sclk_fall && !cs_n_s),
    .serial_in    (mosi_s),
    .serial_out   (tx_bit),
    .parallel_out (rx_byte)
  );

  assign miso = cs_n_s ? 1'b0 : tx_bit; // quiet when not selected

  //////////////////////////////////////////////////
  // checks

  // master must keep sclk parked outside a frame
  a_sclk_quiet : assert property (
    @(posedge clk) disable iff (rst) (cs_n_s && cs_n_d) |-> (sclk_s == sclk_d)
  ) else $error("spi_slave_device: sclk toggled while deselected");

endmodule

`default_nettype wire

//--- design/host_port.sv
`timescale 1ns/1ps
`default_nettype none

// four-phase req/ack front end, turns host commands into master starts
module host_port #(
  parameter int DATA_WIDTH = spi_pkg::spi_data_width
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  req,
  input  host_pkg::host_op_t    op,
  input  logic [DATA_WIDTH-1:0] wdata,
  input  logic                  busy,
  input  logic                  done,
  input  logic [DATA_WIDTH-1:0] rx_data,
  output logic                  ack,
  output logic [DATA_WIDTH-1:0] rdata,
  output logic                  start,
  output logic [DATA_WIDTH-1:0] tx_data
);

  import host_pkg::*;

  host_status_t          state;
  host_op_t              op_q;
  logic                  req_q;
  logic                  req_rise;
  logic [DATA_WIDTH-1:0] last_rx; // byte from the latest frame

  assign req_rise = req && !req_q;

  //////////////////////////////////////////////////
  // handshake sequencing

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state   <= hs_idle;
      op_q    <= op_write;
      req_q   <= 1'b0;
      ack     <= 1'b0;
      start   <= 1'b0;
      last_rx <= '0;
    end else begin
      req_q <= req;
      start <= 1'b0; // single cycle pulse
      if (done) begin
        last_rx <= rx_data;
      end

      case (state)
        hs_idle: begin
          if (req_rise) begin
            op_q  <= op;
            state <= hs_decode;
          end
        end
        hs_decode: begin
          if (op_q == op_read_last) begin
            ack   <= 1'b1; // no spi traffic
            state <= hs_ack;
          end else if (!busy) begin
            start <= 1'b1;
            state <= hs_spi;
          end
        end
        hs_spi: begin
          if (done) begin
            ack   <= 1'b1;
            state <= hs_ack;
          end
        end
        hs_ack: begin
          if (!req) begin
            ack   <= 1'b0;
            state <= hs_idle;
          end
        end
        default: state <= hs_idle;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // payload

  always_ff @(posedge clk) begin
    if (state == hs_idle && req_rise) begin
      tx_data <= wdata;
    end
    if (state == hs_decode && op_q == op_read_last) begin
      rdata <= last_rx;
    end else if (state == hs_spi && done) begin
      rdata <= (op_q == op_write) ? '0 : rx_data; // write hides the reply
    end
  end

  // host owns the release of ack
  a_ack_hold : assert property (
    @(posedge clk) disable iff (rst) (ack && req) |=> ack
  ) else $error("host_port: ack dropped while req high");

endmodule

`default_nettype wire

//--- design/spi_subsystem_top.sv
`timescale 1ns/1ps
`default_nettype none

// host port, master and slave model on one set of spi lines
// the lines come out only so the testbench can watch them
module spi_subsystem_top #(
  parameter int DATA_WIDTH      = spi_pkg::spi_data_width,
  parameter int SCLK_HALFPERIOD = spi_pkg::spi_min_halfperiod
) (
  input  logic                  clk,
  input  logic                  rst,
  // host side
  input  logic                  req,
  input  host_pkg::host_op_t    op,
  input  logic [DATA_WIDTH-1:0] wdata,
  output logic                  ack,
  output logic [DATA_WIDTH-1:0] rdata,
  // spi lines, observation only
  output logic                  sclk,
  output logic                  cs_n,
  output logic                  mosi,
  output logic                  miso
);

  logic                  start;
  logic                  busy;
  logic                  done;
  logic [DATA_WIDTH-1:0] tx_data;
  logic [DATA_WIDTH-1:0] rx_data;

  host_port #(
    .DATA_WIDTH (DATA_WIDTH)
  ) host_port_inst (
    .clk     (clk),
    .rst     (rst),
    .req     (req),
    .op      (op),
    .wdata   (wdata),
    .busy    (busy),
    .done    (done),
    .rx_data (rx_data),
    .ack     (ack),
    .rdata   (rdata),
    .start   (start),
    .tx_data (tx_data)
  );

  spi_master #(
    .DATA_WIDTH      (DATA_WIDTH),
    .SCLK_HALFPERIOD (SCLK_HALFPERIOD)
  ) spi_master_inst (
    .clk     (clk),
    .rst     (rst),
    .start   (start),
    .tx_data (tx_data),
    .miso    (miso),
    .busy    (busy),
    .done    (done),
    .rx_data (rx_data),
    .sclk    (sclk),
    .cs_n    (cs_n),
    .mosi    (mosi)
  );

  spi_slave_device #(
    .DATA_WIDTH (DATA_WIDTH)
  ) spi_slave_device_inst (
    .clk  (clk),
    .rst  (rst),
    .sclk (sclk),
    .cs_n (cs_n),
    .mosi (mosi),
    .miso (miso)
  );

endmodule

`default_nettype wire

//--- tests/tb_spi_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_spi_subsystem;

  import spi_pkg::*;
  import host_pkg::*;

  localparam int DATA_WIDTH      = spi_data_width;
  localparam int SCLK_HALFPERIOD = 4;
  localparam int SPI_LATENCY     = 4 + (2 * DATA_WIDTH + 1) * SCLK_HALFPERIOD; // req to ack
  localparam int ACK_TIMEOUT     = 4 * SPI_LATENCY;
  localparam int RUN_TIMEOUT     = 200000;

  logic                  clk;
  logic                  rst;
  logic                  req;
  host_op_t              op;
  logic [DATA_WIDTH-1:0] wdata;
  logic                  ack;
  logic [DATA_WIDTH-1:0] rdata;
  logic                  sclk;
  logic                  cs_n;
  logic                  mosi;
  logic                  miso;

  int                    errors;
  int                    tests_run;
  int                    tests_passed;
  bit                    timed_out;
  logic [DATA_WIDTH-1:0] reply_model; // byte the slave sends next
  logic [DATA_WIDTH-1:0] last_model;  // byte from the latest frame
  int                    cs_falls;
  int                    sclk_rises;
  logic                  cs_n_prev;
  logic                  sclk_prev;
  logic [DATA_WIDTH-1:0] mosi_seen;   // bits on mosi in the latest frame
  logic [DATA_WIDTH-1:0] miso_seen;   // bits on miso in the latest frame

  spi_subsystem_top #(
    .DATA_WIDTH      (DATA_WIDTH),
    .SCLK_HALFPERIOD (SCLK_HALFPERIOD)
  ) spi_subsystem_top_inst (
    .clk   (clk),
    .rst   (rst),
    .req   (req),
    .op    (op),
    .wdata (wdata),
    .ack   (ack),
    .rdata (rdata),
    .sclk  (sclk),
    .cs_n  (cs_n),
    .mosi  (mosi),
    .miso  (miso)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // line monitor sampled away from the active edge
  always @(negedge clk) begin
    if (!rst && cs_n_prev && !cs_n) cs_falls++;
    if (!rst && !cs_n && sclk && !sclk_prev) sclk_rises++; // only inside a frame
    // mode 1 data is stable at the falling sclk, msb first
    if (!rst && !cs_n && !sclk && sclk_prev === 1'b1) begin
      mosi_seen = {mosi_seen[DATA_WIDTH-2:0], mosi};
      miso_seen = {miso_seen[DATA_WIDTH-2:0], miso};
    end
    cs_n_prev = cs_n;
    sclk_prev = sclk;
  end

  initial begin
    repeat (RUN_TIMEOUT) @(posedge clk);
    $display("run did not finish within %0d clock cycles", RUN_TIMEOUT);
    $display("Verification failed");
    $finish;
  end

  //////////////////////////////////////////////////
  // compare tasks

  task automatic check_data(input string name, input logic [DATA_WIDTH-1:0] got,
                            input logic [DATA_WIDTH-1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_op_cycle(input host_op_t cmd, input string name, input int got,
                                input int exp);
    if (got != exp) begin
      errors++;
      $display("[ERROR] %0t %s (%s) got %0d expected %0d", $time, name, cmd.name(), got, exp);
    end
  endtask

  //////////////////////////////////////////////////
  // echo-previous slave and host result model

  task automatic predict_reply(input host_op_t cmd, input logic [DATA_WIDTH-1:0] wd,
                               output logic [DATA_WIDTH-1:0] exp);
    case (cmd)
      op_xfer: begin
        exp         = reply_model;
        last_model  = reply_model;
        reply_model = wd;
      end
      op_write: begin
        exp         = '0; // reply is dropped by the host port
        last_model  = reply_model;
        reply_model = wd;
      end
      default: exp = last_model;
    endcase
  endtask

  //////////////////////////////////////////////////
  // four-phase handshake driver

  task automatic run_command(input host_op_t cmd, input logic [DATA_WIDTH-1:0] wd,
                             input logic [DATA_WIDTH-1:0] exp);
    int                    gap;
    int                    hold;
    int                    cycles;
    int                    falls0;
    int                    rises0;
    logic [DATA_WIDTH-1:0] held;

    gap = $urandom_range(0, 3);
    repeat (gap) @(posedge clk);
    @(negedge clk);
    check_bit("ack before req", ack, 1'b0);
    falls0 = cs_falls;
    rises0 = sclk_rises;

    @(posedge clk);
    req   <= 1'b1;
    op    <= cmd;
    wdata <= wd;

    cycles = 0;
    @(negedge clk);
    while (ack !== 1'b1 && cycles < ACK_TIMEOUT) begin
      cycles++;
      @(negedge clk);
    end
    if (cycles >= ACK_TIMEOUT) begin
      $display("ack did not rise within %0d cycles, master state %s", ACK_TIMEOUT,
               spi_subsystem_top_inst.spi_master_inst.state.name());
      timed_out = 1'b1;
      return;
    end
    check_op_cycle(cmd, "req to ack cycles", cycles,
                   (cmd == op_read_last) ? 2 : SPI_LATENCY);
    check_data("rdata", rdata, exp);
    held = rdata;

    // ack and rdata must not move while the host holds req
    hold = $urandom_range(0, 4);
    repeat (hold) begin
      @(negedge clk);
      check_bit("ack while req high", ack, 1'b1);
      check_data("rdata while ack high", rdata, held);
    end

    @(posedge clk);
    req <= 1'b0;
    cycles = 0;
    @(negedge clk);
    while (ack !== 1'b0 && cycles < ACK_TIMEOUT) begin
      check_data("rdata while ack high", rdata, held);
      cycles++;
      @(negedge clk);
    end
    if (cycles >= ACK_TIMEOUT) begin
      $display("ack did not fall within %0d cycles after req dropped", ACK_TIMEOUT);
      timed_out = 1'b1;
      return;
    end
    check_op_cycle(cmd, "req fall to ack fall cycles", cycles, 1);

    // one frame per spi command and none for read_last
    check_op_cycle(cmd, "cs_n falling edges", cs_falls - falls0,
                   (cmd == op_read_last) ? 0 : 1);
    check_op_cycle(cmd, "sclk rising edges", sclk_rises - rises0,
                   (cmd == op_read_last) ? 0 : DATA_WIDTH);

    // the slave answers with the byte it got one frame earlier
    if (cmd != op_read_last) begin
      check_data("mosi", mosi_seen, wd);
      check_data("miso", miso_seen, last_model);
    end
  endtask

  //////////////////////////////////////////////////
  // main sequence

  initial begin
    int                    fd;
    int                    fields;
    int                    line_no;
    int                    errs_before;
    string                 line;
    logic [7:0]            op_raw;
    logic [DATA_WIDTH-1:0] wd_raw;
    logic [DATA_WIDTH-1:0] exp_raw;
    logic [DATA_WIDTH-1:0] model_exp;
    host_op_t              cmd;

    void'($urandom(32'h6619_dd64));
    rst         <= 1'b1;
    req         <= 1'b0;
    op          <= op_write;
    wdata       <= '0;
    reply_model = '0;
    last_model  = '0;

    repeat (8) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_bit("ack after reset", ack, 1'b0);
    check_bit("cs_n after reset", cs_n, 1'b1);
    check_bit("sclk after reset", sclk, 1'b0);

    fd = $fopen("tests/spi_stimulus.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file tests/spi_stimulus.txt");
      errors++;
    end else begin
      line_no = 0;
      while (!$feof(fd) && !timed_out) begin
        line   = "";
        fields = 0;
        void'($fgets(line, fd));
        line_no++;
        if (line.len() > 0 && line.getc(0) != 8'h2f) begin // skip comment lines
          fields = $sscanf(line, "%h %h %h", op_raw, wd_raw, exp_raw);
        end
        if (fields == 3) begin
          if (op_raw > 8'd2) begin
            $display("stimulus line %0d holds an unknown opcode %0h", line_no, op_raw);
            errors++;
          end else begin
            cmd = host_op_t'(op_raw[1:0]);
            predict_reply(cmd, wd_raw, model_exp);
            errs_before = errors;
            if (model_exp !== exp_raw) begin
              $display("stimulus line %0d expects %h but the echo rule gives %h",
                       line_no, exp_raw, model_exp);
              errors++;
            end
            run_command(cmd, wd_raw, model_exp);
            tests_run++;
            if (errors == errs_before && !timed_out) tests_passed++;
            $display("test %0d %s wdata %h rdata %h %s", tests_run, cmd.name(), wd_raw,
                     rdata, (errors == errs_before && !timed_out) ? "ok" : "FAILED");
          end
        end
      end
      $fclose(fd);
    end

    $display("tests run %0d, passed %0d, failed %0d, errors %0d", tests_run, tests_passed,
             tests_run - tests_passed, errors);
    if (errors == 0 && !timed_out && tests_run > 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
design/spi_pkg.sv
design/host_pkg.sv
design/spi_shift_reg.sv
design/spi_master.sv
design/spi_slave_device.sv
design/host_port.sv
design/spi_subsystem_top.sv
tests/tb_spi_subsystem.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the spi subsystem testbench with verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 -f vlog.f \
  --top-module tb_spi_subsystem -o tb_sim \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation exited with an error"; exit 1; }

cat sim.log

# the log decides the result
grep -q "Verification failed" sim.log && exit 1 || exit 0

//--- tests/spi_stimulus.txt
// columns: op (0 write, 1 xfer, 2 read_last), wdata, expected rdata, all hex
// the slave answers each frame with the byte it got in the frame before
1 a5 00
1 00 a5
1 ff 00
1 55 ff
1 aa 55
1 80 aa
1 01 80
2 00 80
0 3c 00
1 c3 3c
2 00 3c
0 7e 00
2 00 c3
0 81 00
1 00 81
2 ff 81
2 00 81
1 69 00
1 96 69
2 00 69
1 0f 96
1 f0 0f
